//--- flist.f
+incdir+src
src/mem_sys_pkg.sv
src/axil_to_mem.sv
src/mem_bank.sv
src/mem_ctrl_regs.sv
src/mem_sys_top.sv
test/mem_sys_assert.sv
test/mem_sys_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = mem_sys_tb
FLIST     = flist.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Finished with errors" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "Finished with no errors" $(LOG); then echo "simulation did not finish"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- test/mem_sys_tb.sv
`timescale 1ns/1ns
`include "mem_sys_macros.svh"

module mem_sys_tb;
    import mem_sys_pkg::*;

    localparam logic [1:0]  OKAY_CODE    = 2'b00;
    localparam logic [1:0]  SLVERR_CODE  = 2'b10;
    localparam logic [12:0] REG_CTRL     = 13'h0000;
    localparam logic [12:0] REG_WR_COUNT = 13'h0004;
    localparam logic [12:0] REG_RD_COUNT = 13'h0008;
    localparam logic [12:0] REG_ID       = 13'h000c;
    // roughly 550 transactions of at most 25 cycles, rounded up with margin
    localparam int TIMEOUT_CYCLES = 700 * 25 + 2500;

    typedef logic [31:0] shadow_mem_t [`MEM_SYS_WORDS];

    typedef struct packed {
        logic [31:0] data;
        logic [1:0]  resp;
    } rd_result_t;

    typedef struct packed {
        logic        is_read;
        logic [12:0] addr;
        logic [31:0] exp_data;
        logic [31:0] act_data;
        logic [1:0]  exp_resp;
        logic [1:0]  act_resp;
    } check_t;

    logic      clk = 1'b0;
    logic      reset;
    axil_req_t axil_req;
    axil_rsp_t axil_rsp;

    integer      seed = 32'hc4fb_a809;
    shadow_mem_t shadow_mem;
    logic        shadow_pause;
    logic [31:0] shadow_wr_cnt;
    logic [31:0] shadow_rd_cnt;
    logic [9:0]  written_q [$];
    check_t      check_q [$];
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          test_errs_start = 0;
    int          cycle_count = 0;

    mem_sys_top dut_i (
        .clk      (clk),
        .reset    (reset),
        .axil_req (axil_req),
        .axil_rsp (axil_rsp)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the tests did not end within %0d cycles", TIMEOUT_CYCLES);
            $display("Finished with errors");
            $finish;
        end
    end

    // expected read data and response from the shadow state
    function automatic rd_result_t expected_read(input shadow_mem_t mem, input logic pause_bit,
            input logic [31:0] wr_cnt, input logic [31:0] rd_cnt, input logic [12:0] addr);
        rd_result_t r;
        logic [9:0] word;
        word   = addr[11:2];
        r.data = '0;
        r.resp = OKAY_CODE;
        if (addr[`MEM_SYS_MEM_BIT]) begin
            r.data = mem[word];
        end else if (word > 10'd3) begin
            r.resp = SLVERR_CODE;
        end else begin
            case (word[1:0])
                2'd0:    r.data = {31'b0, pause_bit};
                2'd1:    r.data = wr_cnt;
                2'd2:    r.data = rd_cnt;
                default: r.data = `MEM_SYS_ID;
            endcase
        end
        return r;
    endfunction

    function automatic logic [1:0] expected_write_resp(input logic [12:0] addr);
        if (!addr[`MEM_SYS_MEM_BIT] && addr[11:2] > 10'd3) begin
            return SLVERR_CODE;
        end
        return OKAY_CODE;
    endfunction

    function automatic logic [12:0] mem_addr(input logic [9:0] idx);
        return {1'b1, idx, 2'b00};
    endfunction

    task automatic axil_write(input logic [12:0] addr, input logic [31:0] data,
                              input logic [3:0] strb, output logic [1:0] resp);
        int delay;
        delay = int'($unsigned($random(seed)) % 4);
        @(posedge clk);
        #1;
        axil_req.aw_valid = 1'b1;
        axil_req.aw_addr  = addr;
        axil_req.w_valid  = 1'b1;
        axil_req.w_data   = data;
        axil_req.w_strb   = strb;
        @(negedge clk);
        while (!axil_rsp.aw_ready) begin
            @(negedge clk);
        end
        // address and data are taken in the same cycle
        if (axil_rsp.w_ready !== 1'b1) begin
            errors++;
            $display("MISMATCH w_ready at %h: got %h, expected %h",
                     addr, axil_rsp.w_ready, 1'b1);
        end
        @(posedge clk);
        #1;
        axil_req.aw_valid = 1'b0;
        axil_req.w_valid  = 1'b0;
        @(negedge clk);
        while (!axil_rsp.b_valid) begin
            @(negedge clk);
        end
        // random hold-off on b_ready
        repeat (delay) @(posedge clk);
        @(posedge clk);
        #1;
        axil_req.b_ready = 1'b1;
        @(negedge clk);
        resp = axil_rsp.b_resp;
        @(posedge clk);
        #1;
        axil_req.b_ready = 1'b0;
    endtask

    task automatic axil_read(input logic [12:0] addr, output logic [31:0] data,
                             output logic [1:0] resp);
        int delay;
        delay = int'($unsigned($random(seed)) % 4);
        @(posedge clk);
        #1;
        axil_req.ar_valid = 1'b1;
        axil_req.ar_addr  = addr;
        @(negedge clk);
        while (!axil_rsp.ar_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        axil_req.ar_valid = 1'b0;
        @(negedge clk);
        while (!axil_rsp.r_valid) begin
            @(negedge clk);
        end
        repeat (delay) @(posedge clk);
        @(posedge clk);
        #1;
        axil_req.r_ready = 1'b1;
        @(negedge clk);
        data = axil_rsp.r_data;
        resp = axil_rsp.r_resp;
        @(posedge clk);
        #1;
        axil_req.r_ready = 1'b0;
    endtask

    // write through the bus and update the shadow state
    task automatic do_write(input logic [12:0] addr, input logic [31:0] data,
                            input logic [3:0] strb);
        logic [1:0] resp;
        logic [1:0] exp_resp;
        exp_resp = expected_write_resp(addr);
        axil_write(addr, data, strb, resp);
        if (addr[`MEM_SYS_MEM_BIT]) begin
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) begin
                    shadow_mem[addr[11:2]][8*b +: 8] = data[8*b +: 8];
                end
            end
            shadow_wr_cnt++;
            written_q.push_back(addr[11:2]);
        end else if (addr[11:2] == 10'd0 && strb[0]) begin
            shadow_pause = data[0];
        end
        check_q.push_back(check_t'({1'b0, addr, 32'h0, 32'h0, exp_resp, resp}));
    endtask

    task automatic check_read(input logic [12:0] addr);
        rd_result_t  exp_rd;
        logic [31:0] data;
        logic [1:0]  resp;
        exp_rd = expected_read(shadow_mem, shadow_pause, shadow_wr_cnt, shadow_rd_cnt, addr);
        axil_read(addr, data, resp);
        if (addr[`MEM_SYS_MEM_BIT]) begin
            shadow_rd_cnt++;
        end
        check_q.push_back(check_t'({1'b1, addr, exp_rd.data, data, exp_rd.resp, resp}));
    endtask

    task automatic finish_test(input string name);
        // lets the compare process drain the queue first
        @(negedge clk);
        @(posedge clk);
        tests++;
        if (errors == test_errs_start) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            $display("test %0d %s: %0d errors", tests, name, errors - test_errs_start);
        end
        test_errs_start = errors;
    endtask

    // compare process
    always @(negedge clk) begin
        check_t c;
        while (check_q.size() > 0) begin
            c = check_q.pop_front();
            checks++;
            if (c.is_read && c.act_data !== c.exp_data) begin
                errors++;
                $display("MISMATCH r_data at %h: got %h, expected %h",
                         c.addr, c.act_data, c.exp_data);
            end
            if (c.act_resp !== c.exp_resp) begin
                errors++;
                $display("MISMATCH %s at %h: got %h, expected %h",
                         c.is_read ? "r_resp" : "b_resp", c.addr, c.act_resp, c.exp_resp);
            end
        end
    end

    initial begin
        logic [31:0] data;
        logic [12:0] addr;
        logic [9:0]  idx;
        logic [3:0]  strb;
        logic [1:0]  resp;
        rd_result_t  exp_rd;
        axil_req      = '0;
        reset         = 1'b1;
        shadow_pause  = 1'b0;
        shadow_wr_cnt = '0;
        shadow_rd_cnt = '0;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;

        check_read(REG_ID);
        check_read(REG_CTRL);
        check_read(REG_WR_COUNT);
        check_read(REG_RD_COUNT);
        finish_test("register values after reset");

        for (int i = 0; i < 200; i++) begin
            idx = 10'($unsigned($random(seed)) % `MEM_SYS_WORDS);
            do_write(mem_addr(idx), $random(seed), 4'hf);
        end
        foreach (written_q[i]) begin
            check_read(mem_addr(written_q[i]));
        end
        finish_test("random full-word writes and reads");

        for (int i = 0; i < 40; i++) begin
            idx  = written_q[$unsigned($random(seed)) % written_q.size()];
            strb = 4'(1 + $unsigned($random(seed)) % 14);
            do_write(mem_addr(idx), $random(seed), strb);
            check_read(mem_addr(idx));
        end
        finish_test("partial strobe writes");

        check_read(REG_WR_COUNT);
        check_read(REG_RD_COUNT);
        finish_test("access counters");

        do_write(REG_CTRL, 32'h1, 4'hf);
        check_read(REG_CTRL);
        addr   = mem_addr(written_q[0]);
        exp_rd = expected_read(shadow_mem, shadow_pause, shadow_wr_cnt, shadow_rd_cnt, addr);
        fork
            axil_read(addr, data, resp);
            begin
                repeat (31) begin
                    @(negedge clk);
                    if (axil_rsp.r_valid) begin
                        errors++;
                        $display("error: r_valid appeared for a memory read while paused");
                    end
                end
                // register writes still pass while paused
                do_write(REG_CTRL, 32'h0, 4'hf);
            end
        join
        shadow_rd_cnt++;
        check_q.push_back(check_t'({1'b1, addr, exp_rd.data, data, exp_rd.resp, resp}));
        finish_test("pause holds memory reads");

        for (int i = 0; i < 20; i++) begin
            idx  = 10'(4 + $unsigned($random(seed)) % 1020);
            addr = {1'b0, idx, 2'b00};
            do_write(addr, $random(seed), 4'hf);
            check_read(addr);
        end
        do_write(REG_WR_COUNT, 32'hffff_ffff, 4'hf);
        do_write(REG_ID, 32'h0, 4'hf);
        check_read(REG_WR_COUNT);
        check_read(REG_ID);
        check_read(mem_addr(written_q[1]));
        finish_test("register errors and ignored writes");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- test/mem_sys_assert.sv
`timescale 1ns/1ns
`include "mem_sys_macros.svh"

module mem_sys_assert (
    input logic                       clk,
    input logic                       reset,
    input mem_sys_pkg::axil_req_t     axil_req,
    input mem_sys_pkg::axil_rsp_t     axil_rsp,
    input logic                       pause
);

    // responses stay up until the master takes them
    b_hold: assert property (@(posedge clk) disable iff (reset)
        axil_rsp.b_valid && !axil_req.b_ready |=> axil_rsp.b_valid)
        else $error("b_valid dropped before b_ready");

    r_hold: assert property (@(posedge clk) disable iff (reset)
        axil_rsp.r_valid && !axil_req.r_ready |=> axil_rsp.r_valid && $stable(axil_rsp.r_data))
        else $error("r_valid dropped or r_data changed before r_ready");

    aw_ready_valid: assert property (@(posedge clk) disable iff (reset)
        axil_rsp.aw_ready |-> axil_req.aw_valid)
        else $error("aw_ready high without aw_valid");

    no_mem_accept_paused: assert property (@(posedge clk) disable iff (reset)
        (axil_rsp.aw_ready && axil_req.aw_addr[`MEM_SYS_MEM_BIT]) ||
        (axil_rsp.ar_ready && axil_req.ar_addr[`MEM_SYS_MEM_BIT]) |-> !pause)
        else $error("memory region access accepted while paused");

endmodule

bind axil_to_mem mem_sys_assert assert_i (
    .clk      (clk),
    .reset    (reset),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp),
    .pause    (pause)
);

//--- src/mem_sys_top.sv
`timescale 1ns/1ns
`include "mem_sys_macros.svh"

module mem_sys_top (
    input  logic                   clk,
    input  logic                   reset,
    input  mem_sys_pkg::axil_req_t axil_req,
    output mem_sys_pkg::axil_rsp_t axil_rsp
);
    import mem_sys_pkg::*;

    mem_req_t                   mem_req;
    logic [`MEM_SYS_DATA_W-1:0] mem_rdata;
    logic [`MEM_SYS_DATA_W-1:0] reg_rdata;
    logic                       reg_err;
    logic                       pause;

    axil_to_mem bridge_i (
        .clk       (clk),
        .reset     (reset),

        .axil_req  (axil_req),
        .axil_rsp  (axil_rsp),

        .pause     (pause),

        .mem_req   (mem_req),
        .mem_rdata (mem_rdata),
        .reg_rdata (reg_rdata),
        .reg_err   (reg_err)
    );

    mem_bank bank_i (
        .clk     (clk),
        .mem_req (mem_req),
        .rdata   (mem_rdata)
    );

    // sits beside the bridge and steers it through pause
    mem_ctrl_regs regs_i (
        .clk       (clk),
        .reset     (reset),
        .mem_req   (mem_req),
        .pause     (pause),
        .reg_rdata (reg_rdata),
        .reg_err   (reg_err)
    );

endmodule

//--- src/mem_ctrl_regs.sv
`timescale 1ns/1ns
`include "mem_sys_macros.svh"

module mem_ctrl_regs (
    input  logic                       clk,
    input  logic                       reset,
    input  mem_sys_pkg::mem_req_t      mem_req,
    output logic                       pause,
    output logic [`MEM_SYS_DATA_W-1:0] reg_rdata,
    output logic                       reg_err
);
    import mem_sys_pkg::*;

    logic [`MEM_SYS_DATA_W-1:0] wr_count;
    logic [`MEM_SYS_DATA_W-1:0] rd_count;

    reg_index_e reg_idx;
    logic       reg_wr;

    assign reg_idx = reg_index_e'(mem_req.idx[1:0]);

    // anything past ID is not a register
    assign reg_err = |mem_req.idx[`MEM_SYS_IDX_W-1:2];

    assign reg_wr = mem_req.req && !mem_req.mem_sel && mem_req.we && !reg_err;

    always_ff @(posedge clk) begin
        if (reset) begin
            pause    <= 1'b0;
            wr_count <= '0;
            rd_count <= '0;
        end else begin
            // only CTRL is writable, counters and ID ignore writes
            if (reg_wr && reg_idx == CTRL && mem_req.be[0]) begin
                pause <= mem_req.wdata[0];
            end
            // counters just wrap
            if (mem_req.req && mem_req.mem_sel) begin
                if (mem_req.we) begin
                    wr_count <= wr_count + 1'b1;
                end else begin
                    rd_count <= rd_count + 1'b1;
                end
            end
        end
    end

    always_comb begin
        reg_rdata = '0;
        if (!reg_err) begin
            case (reg_idx)
                CTRL:     reg_rdata = {{(`MEM_SYS_DATA_W-1){1'b0}}, pause};
                WR_COUNT: reg_rdata = wr_count;
                RD_COUNT: reg_rdata = rd_count;
                ID:       reg_rdata = `MEM_SYS_ID;
                default:  reg_rdata = '0;
            endcase
        end
    end

endmodule

//--- src/mem_bank.sv
`timescale 1ns/1ns
`include "mem_sys_macros.svh"

module mem_bank (
    input  logic                       clk,
    input  mem_sys_pkg::mem_req_t      mem_req,
    output logic [`MEM_SYS_DATA_W-1:0] rdata
);

    logic [`MEM_SYS_DATA_W-1:0] mem [`MEM_SYS_WORDS];

    logic access;

    // only requests aimed at the memory region
    assign access = mem_req.req && mem_req.mem_sel;

    always_ff @(posedge clk) begin
        if (access && mem_req.we) begin
            for (int i = 0; i < `MEM_SYS_STRB_W; i++) begin
                if (mem_req.be[i]) begin
                    mem[mem_req.idx][8*i +: 8] <= mem_req.wdata[8*i +: 8];
                end
            end
        end
    end

    // read port, data shows up the cycle after the request
    always_ff @(posedge clk) begin
        if (access && !mem_req.we) begin
            rdata <= mem[mem_req.idx];
        end
    end

endmodule

//--- src/axil_to_mem.sv
`timescale 1ns/1ns
`include "mem_sys_macros.svh"

module axil_to_mem (
    input  logic                       clk,
    input  logic                       reset,

    input  mem_sys_pkg::axil_req_t     axil_req,
    output mem_sys_pkg::axil_rsp_t     axil_rsp,

    input  logic                       pause,

    output mem_sys_pkg::mem_req_t      mem_req,
    input  logic [`MEM_SYS_DATA_W-1:0] mem_rdata,
    input  logic [`MEM_SYS_DATA_W-1:0] reg_rdata,
    input  logic                       reg_err
);
    import mem_sys_pkg::*;

    bridge_state_e state;
    logic          issued;

    logic                       wr_ok;
    logic                       rd_ok;
    logic                       wr_accept;
    logic                       rd_accept;

    // captured request
    logic                       mem_sel_q;
    logic [`MEM_SYS_IDX_W-1:0]  idx_q;
    logic [`MEM_SYS_STRB_W-1:0] strb_q;
    logic [`MEM_SYS_DATA_W-1:0] wdata_q;

    // captured response
    axil_resp_e                 resp_q;
    logic [`MEM_SYS_DATA_W-1:0] rdata_q;

    // memory region stays closed while paused, registers never do
    assign wr_ok = axil_req.aw_valid && axil_req.w_valid &&
                   !(axil_req.aw_addr[`MEM_SYS_MEM_BIT] && pause);
    assign rd_ok = axil_req.ar_valid &&
                   !(axil_req.ar_addr[`MEM_SYS_MEM_BIT] && pause);

    // write wins when both can go
    assign wr_accept = (state == IDLE) && wr_ok;
    assign rd_accept = (state == IDLE) && rd_ok && !wr_accept;

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= IDLE;
            issued <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (wr_accept) begin
                        state <= WRITE_ACCESS;
                    end else if (rd_accept) begin
                        state <= READ_ACCESS;
                    end
                end
                WRITE_ACCESS: begin
                    state <= WRITE_RESP;
                end
                READ_ACCESS: begin
                    // first cycle issues, second cycle takes the data
                    if (issued) begin
                        issued <= 1'b0;
                        state  <= READ_RESP;
                    end else begin
                        issued <= 1'b1;
                    end
                end
                WRITE_RESP: begin
                    if (axil_req.b_ready) begin
                        state <= IDLE;
                    end
                end
                READ_RESP: begin
                    if (axil_req.r_ready) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_accept) begin
            mem_sel_q <= axil_req.aw_addr[`MEM_SYS_MEM_BIT];
            idx_q     <= axil_req.aw_addr[`MEM_SYS_IDX_W+1:2];
            strb_q    <= axil_req.w_strb;
            wdata_q   <= axil_req.w_data;
        end else if (rd_accept) begin
            mem_sel_q <= axil_req.ar_addr[`MEM_SYS_MEM_BIT];
            idx_q     <= axil_req.ar_addr[`MEM_SYS_IDX_W+1:2];
            strb_q    <= '0;
        end

        if (state == WRITE_ACCESS) begin
            resp_q <= (!mem_sel_q && reg_err) ? RESP_SLVERR : RESP_OKAY;
        end else if (state == READ_ACCESS && issued) begin
            resp_q  <= (!mem_sel_q && reg_err) ? RESP_SLVERR : RESP_OKAY;
            rdata_q <= mem_sel_q ? mem_rdata : reg_rdata;
        end
    end

    // single request per transaction, fields stay put until the next one
    always_comb begin
        mem_req.req     = (state == WRITE_ACCESS) || (state == READ_ACCESS && !issued);
        mem_req.mem_sel = mem_sel_q;
        mem_req.we      = (state == WRITE_ACCESS);
        mem_req.idx     = idx_q;
        mem_req.be      = strb_q;
        mem_req.wdata   = wdata_q;
    end

    always_comb begin
        axil_rsp.aw_ready = wr_accept;
        axil_rsp.w_ready  = wr_accept;
        axil_rsp.b_valid  = (state == WRITE_RESP);
        axil_rsp.b_resp   = resp_q;
        axil_rsp.ar_ready = rd_accept;
        axil_rsp.r_valid  = (state == READ_RESP);
        axil_rsp.r_data   = rdata_q;
        axil_rsp.r_resp   = resp_q;
    end

endmodule

//--- src/mem_sys_pkg.sv
`include "mem_sys_macros.svh"

package mem_sys_pkg;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axil_resp_e;

    // master driven side of the axi4-lite port
    typedef struct packed {
        logic                         aw_valid;
        logic [`MEM_SYS_ADDR_W-1:0]   aw_addr;
        logic                         w_valid;
        logic [`MEM_SYS_DATA_W-1:0]   w_data;
        logic [`MEM_SYS_STRB_W-1:0]   w_strb;
        logic                         b_ready;
        logic                         ar_valid;
        logic [`MEM_SYS_ADDR_W-1:0]   ar_addr;
        logic                         r_ready;
    } axil_req_t;

    // slave driven side
    typedef struct packed {
        logic                         aw_ready;
        logic                         w_ready;
        logic                         b_valid;
        axil_resp_e                   b_resp;
        logic                         ar_ready;
        logic                         r_valid;
        logic [`MEM_SYS_DATA_W-1:0]   r_data;
        axil_resp_e                   r_resp;
    } axil_rsp_t;

    // one access towards the memory or the register block
    typedef struct packed {
        logic                         req;
        logic                         mem_sel;
        logic                         we;
        logic [`MEM_SYS_IDX_W-1:0]    idx;
        logic [`MEM_SYS_STRB_W-1:0]   be;
        logic [`MEM_SYS_DATA_W-1:0]   wdata;
    } mem_req_t;

    typedef enum logic [2:0] {
        IDLE,
        WRITE_ACCESS,
        READ_ACCESS,
        WRITE_RESP,
        READ_RESP
    } bridge_state_e;

    // register word offsets
    typedef enum logic [1:0] {
        CTRL     = 2'd0,
        WR_COUNT = 2'd1,
        RD_COUNT = 2'd2,
        ID       = 2'd3
    } reg_index_e;

endpackage

//--- src/mem_sys_macros.svh
`ifndef MEM_SYS_MACROS_SVH
`define MEM_SYS_MACROS_SVH

// bus widths
`define MEM_SYS_ADDR_W 13
`define MEM_SYS_DATA_W 32
`define MEM_SYS_STRB_W (`MEM_SYS_DATA_W / 8)

// word memory geometry
`define MEM_SYS_WORDS 1024
`define MEM_SYS_IDX_W 10

// region decode, bit 12 set means word memory
`define MEM_SYS_MEM_BIT 12
`define MEM_SYS_REG_BASE 13'h0000
`define MEM_SYS_MEM_BASE 13'h1000

// identification word, "MEM1" in ascii
`define MEM_SYS_ID 32'h4d45_4d31

`endif
